// File: icache_pkg.sv
/*
 * Shared widths, types and the backing memory content rule of the fetch subsystem.
 * Imported by the RTL and by the testbench.
 */
package icache_pkg;

  localparam int unsigned FETCH_AW      = 32;
  localparam int unsigned FETCH_DW      = 32;
  localparam int unsigned LINE_WIDTH    = 128;
  localparam int unsigned LINE_ALIGN    = 4;
  localparam int unsigned FETCH_ALIGN   = 2;
  localparam int unsigned L0_LINE_COUNT = 4;
  localparam int unsigned TAG_WIDTH     = FETCH_AW - LINE_ALIGN;
  localparam int unsigned FETCH_PKTS    = 4;
  localparam int unsigned MEM_LATENCY   = 3;

  // RISC-V major opcodes used by the predictor and the memory rule
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  typedef logic [FETCH_AW-1:0]                  addr_t;
  typedef logic [FETCH_DW-1:0]                  word_t;
  typedef logic [LINE_WIDTH-1:0]                line_t;
  typedef logic [TAG_WIDTH-1:0]                 tag_t;
  typedef logic [$clog2(L0_LINE_COUNT)-1:0]     line_idx_t;

  typedef struct packed {
    addr_t addr;
    logic  is_prefetch;
  } refill_req_t;

  typedef struct packed {
    logic l0_hit;
    logic l0_miss;
    logic l0_prefetch;
  } icache_events_t;

  typedef enum logic {
    MEM_IDLE,
    MEM_BUSY
  } mem_state_e;

  // Word 6 of every 16 is JAL +48, word 13 is BEQ -32, the rest ADDI with the word index
  function automatic word_t mem_word(input addr_t addr);
    logic [FETCH_AW-FETCH_ALIGN-1:0] w;
    logic [20:0] j_imm;
    logic [12:0] b_imm;
    word_t insn;
    w     = addr[FETCH_AW-1:FETCH_ALIGN];
    j_imm = 21'd48;
    // Two's complement of -32 in 13 bits
    b_imm = 13'h1fe0;
    if (w[3:0] == 4'd6) begin
      insn = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12], 5'd0, OPC_JAL};
    end else if (w[3:0] == 4'd13) begin
      insn = {b_imm[12], b_imm[10:5], 5'd2, 5'd1, 3'b000, b_imm[4:1], b_imm[11], OPC_BRANCH};
    end else begin
      insn = {w[11:0], 5'd0, 3'b000, 5'd1, OPC_OP_IMM};
    end
    return insn;
  endfunction

endpackage

// File: line_memory.sv
/*
 * Read-only backing line store model. Takes one line request at a time and
 * answers with a one-cycle response pulse after a fixed latency.
 */
module line_memory import icache_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  refill_req_t req_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  output line_t       rsp_line_o,
  output logic        rsp_valid_o
);

  typedef logic [$clog2(MEM_LATENCY)-1:0] lat_cnt_t;

  mem_state_e state_q;
  lat_cnt_t   cnt_q;
  tag_t       line_tag_q;

  assign req_ready_o = (state_q == MEM_IDLE);
  assign rsp_valid_o = (state_q == MEM_BUSY) && (cnt_q == '0);

  // ---------------------------------------
  // Latency FSM
  // ---------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= MEM_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        MEM_IDLE: begin
          if (req_valid_i) begin
            state_q <= MEM_BUSY;
            cnt_q   <= lat_cnt_t'(MEM_LATENCY - 1);
          end
        end
        MEM_BUSY: begin
          // Response goes out in the cycle the counter reads zero
          if (cnt_q == '0) begin
            state_q <= MEM_IDLE;
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        default: state_q <= MEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      line_tag_q <= req_i.addr[FETCH_AW-1:LINE_ALIGN];
    end
  end

  // Line content is generated from the address
  always_comb begin
    for (int k = 0; k < FETCH_PKTS; k++) begin
      rsp_line_o[k*FETCH_DW +: FETCH_DW] = mem_word({line_tag_q, LINE_ALIGN'(k << FETCH_ALIGN)});
    end
  end

endmodule

// File: branch_prefetch_predictor.sv
/*
 * Static next-line predictor. Decodes the line that hit and picks the first
 * JAL or backward branch at or after the fetched word, else the next line.
 */
module branch_prefetch_predictor import icache_pkg::*; (
  input  addr_t fetch_addr_i,
  input  line_t line_i,
  output addr_t pf_addr_o
);

  word_t [FETCH_PKTS-1:0] words;
  logic  [FETCH_PKTS-1:0] is_jal;
  logic  [FETCH_PKTS-1:0] is_br_taken;
  logic  [FETCH_PKTS-1:0] mask;
  logic  [FETCH_PKTS-1:0] flagged;
  logic  [LINE_ALIGN-FETCH_ALIGN-1:0] word_sel;
  logic  [LINE_ALIGN-FETCH_ALIGN-1:0] first_idx;
  logic  found;
  word_t sel_word;
  addr_t j_imm;
  addr_t b_imm;
  addr_t base_addr;
  addr_t offset;
  addr_t target;

  assign words    = line_i;
  assign word_sel = fetch_addr_i[LINE_ALIGN-1:FETCH_ALIGN];

  // Pre-decode each word of the line
  always_comb begin
    is_jal      = '0;
    is_br_taken = '0;
    for (int i = 0; i < FETCH_PKTS; i++) begin
      case (words[i][6:0])
        OPC_JAL: is_jal[i] = 1'b1;
        // Backward branches are predicted taken; funct3 010/011 are not branches
        OPC_BRANCH: is_br_taken[i] = words[i][31] & (words[i][14:13] != 2'b01);
        default: ;
      endcase
    end
  end

  // Ignore the words before the one being fetched
  assign mask    = {FETCH_PKTS{1'b1}} << word_sel;
  assign flagged = mask & (is_jal | is_br_taken);

  // Lowest flagged index wins
  always_comb begin
    found     = 1'b0;
    first_idx = '0;
    for (int i = FETCH_PKTS - 1; i >= 0; i--) begin
      if (flagged[i]) begin
        found     = 1'b1;
        first_idx = i[LINE_ALIGN-FETCH_ALIGN-1:0];
      end
    end
  end

  assign sel_word = words[first_idx];
  assign j_imm = {{11{sel_word[31]}}, sel_word[31], sel_word[19:12], sel_word[20],
                  sel_word[30:21], 1'b0};
  assign b_imm = {{19{sel_word[31]}}, sel_word[31], sel_word[7], sel_word[30:25],
                  sel_word[11:8], 1'b0};

  // ---------------------------------------
  // Target address
  // ---------------------------------------
  always_comb begin
    base_addr = fetch_addr_i;
    offset    = addr_t'(1 << LINE_ALIGN);
    if (found) begin
      base_addr = {fetch_addr_i[FETCH_AW-1:LINE_ALIGN], first_idx, {FETCH_ALIGN{1'b0}}};
      offset    = is_jal[first_idx] ? j_imm : b_imm;
    end
  end

  assign target    = base_addr + offset;
  assign pf_addr_o = {target[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};

endmodule

// File: l0_icache.sv
/*
 * Fully associative L0 instruction cache with four lines and round-robin
 * replacement. Issues line refills on a miss and one prefetch on a hit.
 */
module l0_icache import icache_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           flush_i,
  input  logic           enable_prefetch_i,
  input  addr_t          fetch_addr_i,
  input  logic           fetch_valid_i,
  output word_t          fetch_data_o,
  output logic           fetch_ready_o,
  output line_t          hit_line_o,
  input  addr_t          pf_addr_i,
  output refill_req_t    refill_req_o,
  output logic           refill_valid_o,
  input  logic           refill_ready_i,
  input  line_t          rsp_line_i,
  input  logic           rsp_valid_i,
  output icache_events_t events_o
);

  tag_t  fetch_tag;
  tag_t  pf_tag;
  tag_t  tag_q [L0_LINE_COUNT];
  line_t data_q [L0_LINE_COUNT];
  logic [L0_LINE_COUNT-1:0] valid_q;
  logic [L0_LINE_COUNT-1:0] hit;
  logic [L0_LINE_COUNT-1:0] hit_pf;
  logic hit_any;
  logic hit_pf_any;
  logic miss;
  logic miss_q;
  logic new_miss;
  logic latch_pf;
  logic evict_req;
  line_idx_t rr_q;
  line_idx_t pending_line_q;
  logic pending_q;
  logic pf_vld_q;
  addr_t pf_addr_q;
  logic refill_accept;
  logic pf_accept;

  assign fetch_tag = fetch_addr_i[FETCH_AW-1:LINE_ALIGN];
  assign pf_tag    = pf_addr_i[FETCH_AW-1:LINE_ALIGN];

  // ---------------------------------------
  // Tag compare and data select
  // ---------------------------------------
  for (genvar i = 0; i < L0_LINE_COUNT; i++) begin : gen_cmp
    assign hit[i]    = valid_q[i] & (tag_q[i] == fetch_tag);
    assign hit_pf[i] = valid_q[i] & (tag_q[i] == pf_tag);
  end

  assign hit_any       = |hit;
  assign hit_pf_any    = |hit_pf;
  assign fetch_ready_o = hit_any;

  always_comb begin
    hit_line_o = '0;
    for (int i = 0; i < L0_LINE_COUNT; i++) begin
      hit_line_o |= {LINE_WIDTH{hit[i]}} & data_q[i];
    end
  end

  assign fetch_data_o = hit_line_o[fetch_addr_i[LINE_ALIGN-1:FETCH_ALIGN] * FETCH_DW +: FETCH_DW];

  // A held miss evicts only once, even while the request waits for the memory
  assign miss      = fetch_valid_i & ~hit_any & ~pending_q;
  assign new_miss  = miss & ~miss_q;
  assign latch_pf  = enable_prefetch_i & fetch_valid_i & hit_any & ~hit_pf_any
                   & ~pending_q & ~pf_vld_q;
  assign evict_req = new_miss | latch_pf;

  // ---------------------------------------
  // Arrays and round-robin evictor
  // ---------------------------------------
  always_ff @(posedge clk_i) begin
    if (evict_req) begin
      tag_q[rr_q] <= latch_pf ? pf_tag : fetch_tag;
    end
    if (rsp_valid_i) begin
      data_q[pending_line_q] <= rsp_line_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q        <= '0;
      rr_q           <= '0;
      pending_line_q <= '0;
      miss_q         <= 1'b0;
    end else begin
      miss_q <= miss;
      if (evict_req) begin
        rr_q           <= rr_q + 1'b1;
        pending_line_q <= rr_q;
      end
      if (flush_i) begin
        valid_q <= '0;
      end else begin
        if (evict_req) valid_q[rr_q] <= 1'b0;
        if (rsp_valid_i && pending_q) valid_q[pending_line_q] <= 1'b1;
      end
    end
  end

  // ---------------------------------------
  // Refill and prefetch requests
  // ---------------------------------------
  assign refill_accept = miss & refill_ready_i;
  assign pf_accept     = pf_vld_q & ~miss & refill_ready_i;

  // Demand refill wins over a queued prefetch
  always_comb begin
    refill_req_o.addr        = pf_addr_q;
    refill_req_o.is_prefetch = 1'b1;
    refill_valid_o           = pf_vld_q;
    if (miss) begin
      refill_req_o.addr        = {fetch_tag, {LINE_ALIGN{1'b0}}};
      refill_req_o.is_prefetch = 1'b0;
      refill_valid_o           = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (latch_pf) begin
      pf_addr_q <= pf_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      pf_vld_q  <= 1'b0;
    end else begin
      if (pending_q) begin
        if (rsp_valid_i) pending_q <= 1'b0;
      end else if (refill_accept || latch_pf) begin
        pending_q <= 1'b1;
      end
      if (latch_pf) begin
        pf_vld_q <= 1'b1;
      end else if (pf_accept) begin
        pf_vld_q <= 1'b0;
      end
    end
  end

  // Performance events
  assign events_o.l0_hit      = hit_any & fetch_valid_i;
  assign events_o.l0_miss     = miss;
  assign events_o.l0_prefetch = latch_pf;

endmodule

// File: icache_subsys_top.sv
/*
 * Instruction fetch subsystem: L0 cache, branch-aware prefetch predictor and
 * backing line memory.
 */
module icache_subsys_top import icache_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_ni,
  input  addr_t          fetch_addr_i,
  input  logic           fetch_valid_i,
  output word_t          fetch_data_o,
  output logic           fetch_ready_o,
  input  logic           flush_i,
  input  logic           enable_prefetch_i,
  output icache_events_t events_o
);

  line_t       hit_line;
  addr_t       pf_addr;
  refill_req_t refill_req;
  logic        refill_valid;
  logic        refill_ready;
  line_t       rsp_line;
  logic        rsp_valid;

  l0_icache i_l0_icache (
    .clk_i,
    .rst_ni,
    .flush_i,
    .enable_prefetch_i,
    .fetch_addr_i,
    .fetch_valid_i,
    .fetch_data_o,
    .fetch_ready_o,
    .hit_line_o     (hit_line),
    .pf_addr_i      (pf_addr),
    .refill_req_o   (refill_req),
    .refill_valid_o (refill_valid),
    .refill_ready_i (refill_ready),
    .rsp_line_i     (rsp_line),
    .rsp_valid_i    (rsp_valid),
    .events_o
  );

  branch_prefetch_predictor i_predictor (
    .fetch_addr_i,
    .line_i    (hit_line),
    .pf_addr_o (pf_addr)
  );

  line_memory i_line_memory (
    .clk_i,
    .rst_ni,
    .req_i       (refill_req),
    .req_valid_i (refill_valid),
    .req_ready_o (refill_ready),
    .rsp_line_o  (rsp_line),
    .rsp_valid_o (rsp_valid)
  );

endmodule

// File: icache_subsys_assertions.sv
/*
 * Protocol assertions for the L0 cache, bound into every l0_icache instance.
 * Covers fetch and refill request stability and the uniqueness of a hit.
 */
module icache_subsys_assertions import icache_pkg::*; (
  input logic                     clk_i,
  input logic                     rst_ni,
  input logic                     fetch_valid_i,
  input addr_t                    fetch_addr_i,
  input logic                     fetch_ready_i,
  input logic                     refill_valid_i,
  input logic                     refill_ready_i,
  input refill_req_t              refill_req_i,
  input logic [L0_LINE_COUNT-1:0] hit_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0;

  // A fetch that has not completed keeps its request unchanged
  fetch_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fetch_valid_i && !fetch_ready_i |=> fetch_valid_i && $stable(fetch_addr_i))
    else begin
      $error("fetch request changed while waiting for fetch_ready_o");
      fail_count++;
    end

  // A refill request stalled by the memory stays stable
  refill_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    refill_valid_i && !refill_ready_i |=> refill_valid_i && $stable(refill_req_i))
    else begin
      $error("refill request changed while stalled");
      fail_count++;
    end

  // Full tags make a hit unique
  single_hit_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_i))
    else begin
      $error("more than one L0 line hit");
      fail_count++;
    end

endmodule

bind l0_icache icache_subsys_assertions u_assertions (
  .clk_i,
  .rst_ni,
  .fetch_valid_i,
  .fetch_addr_i,
  .fetch_ready_i  (fetch_ready_o),
  .refill_valid_i (refill_valid_o),
  .refill_ready_i,
  .refill_req_i   (refill_req_o),
  .hit_i          (hit)
);

// File: icache_subsys_checker.sv
/*
 * Reference model and comparisons for the fetch subsystem. Watches the top
 * ports, checks every returned word and the events seen in a fetch's first cycle.
 */
module icache_subsys_checker import icache_pkg::*; (
  input logic           clk_i,
  input logic           rst_ni,
  input addr_t          fetch_addr_i,
  input logic           fetch_valid_i,
  input word_t          fetch_data_i,
  input logic           fetch_ready_i,
  input icache_events_t events_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int    error_count   = 0;
  int    check_count   = 0;
  int    tests_run     = 0;
  int    tests_bad     = 0;
  int    test_err_base = 0;
  int    pf_count      = 0;
  int    pf_base       = 0;
  logic  in_flight     = 1'b0;
  logic  first_ready;
  logic  first_hit;
  logic  first_miss;
  word_t expected;

  // ----------------------------------------
  // Memory and predictor model
  // ----------------------------------------
  // JAL x0,+48 at word 6 of 16, BEQ x1,x2,-32 at word 13, else ADDI x1,x0,index
  function automatic word_t model_word(input addr_t addr);
    addr_t w;
    w = addr >> 2;
    case (w[3:0])
      4'd6:    return 32'h0300_006f;
      4'd13:   return 32'hfe20_80e3;
      default: return {w[11:0], 20'h0_0093};
    endcase
  endfunction

  // First JAL or backward branch at or after the fetched word, else next line
  function automatic addr_t predicted_line(input addr_t addr);
    addr_t target;
    addr_t word_addr;
    logic  found;
    target = {addr[31:4], 4'h0} + 32'd16;
    found  = 1'b0;
    for (int k = int'(addr[3:2]); k < 4; k++) begin
      word_addr = {addr[31:4], 4'h0} + addr_t'(k * 4);
      if (!found && word_addr[5:2] == 4'd6) begin
        target = word_addr + 32'd48;
        found  = 1'b1;
      end else if (!found && word_addr[5:2] == 4'd13) begin
        target = word_addr - 32'd32;
        found  = 1'b1;
      end
    end
    return {target[31:4], 4'h0};
  endfunction

  // ----------------------------------------
  // Port monitor
  // ----------------------------------------
  always @(posedge clk_i) begin
    if (rst_ni) begin
      if (events_i.l0_prefetch) pf_count++;
      if (fetch_valid_i && !in_flight) begin
        first_ready = fetch_ready_i;
        first_hit   = events_i.l0_hit;
        first_miss  = events_i.l0_miss;
      end
      if (fetch_valid_i && fetch_ready_i) begin
        expected = model_word(fetch_addr_i);
        check_count++;
        if (fetch_data_i !== expected) begin
          error_count++;
          $display("ERROR %0t ns: fetch %h returned %h, expected %h",
                   $time, fetch_addr_i, fetch_data_i, expected);
        end
        in_flight = 1'b0;
      end else if (fetch_valid_i) begin
        in_flight = 1'b1;
      end
    end
  end

  task automatic expect_bit(input string what, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("ERROR %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_first_cycle(input logic exp_ready, input logic exp_hit,
                                   input logic exp_miss);
    expect_bit("fetch_ready_o in first cycle", first_ready, exp_ready);
    expect_bit("l0_hit in first cycle", first_hit, exp_hit);
    expect_bit("l0_miss in first cycle", first_miss, exp_miss);
  endtask

  task automatic mark_prefetch();
    pf_base = pf_count;
  endtask

  task automatic compare_prefetch_count(input int exp);
    check_count++;
    if (pf_count - pf_base != exp) begin
      error_count++;
      $display("ERROR %0t ns: l0_prefetch pulsed %0d times, expected %0d",
               $time, pf_count - pf_base, exp);
    end
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = error_count - test_err_base;
    tests_run++;
    if (errs != 0) tests_bad++;
    $display("test %s done with %0d errors", name, errs);
    test_err_base = error_count;
  endtask

  task automatic report();
    $display("Summary: %0d tests, %0d with errors, %0d checks, %0d errors",
             tests_run, tests_bad, check_count, error_count);
  endtask

endmodule

// File: tb_icache_subsys.sv
/*
 * Testbench top for the fetch subsystem. Runs random and directed fetch
 * sequences against the DUT and gives the verdict from the checker's counts.
 */
module tb_icache_subsys import icache_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic           clk;
  logic           rst_n;
  addr_t          fetch_addr;
  logic           fetch_valid;
  word_t          fetch_data;
  logic           fetch_ready;
  logic           flush;
  logic           enable_prefetch;
  icache_events_t events;
  integer         seed;
  logic           timed_out;

  icache_subsys_top uut (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .fetch_addr_i      (fetch_addr),
    .fetch_valid_i     (fetch_valid),
    .fetch_data_o      (fetch_data),
    .fetch_ready_o     (fetch_ready),
    .flush_i           (flush),
    .enable_prefetch_i (enable_prefetch),
    .events_o          (events)
  );

  icache_subsys_checker u_checker (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .fetch_addr_i  (fetch_addr),
    .fetch_valid_i (fetch_valid),
    .fetch_data_i  (fetch_data),
    .fetch_ready_i (fetch_ready),
    .events_i      (events)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Word-aligned address inside a 1 KiB window
  function automatic addr_t rand_addr();
    return 32'h0000_2000 | (addr_t'($random(seed)) & 32'h0000_03fc);
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // One fetch, held until fetch_ready, at most 64 cycles
  task automatic fetch_word(input addr_t addr);
    int waited;
    fetch_addr  <= addr;
    fetch_valid <= 1'b1;
    waited = 0;
    @(posedge clk);
    while (!fetch_ready && waited < 64) begin
      @(posedge clk);
      waited++;
    end
    if (!fetch_ready) begin
      $display("Fetch to address %h never completed within 64 cycles", addr);
      timed_out = 1'b1;
    end
    fetch_valid <= 1'b0;
    @(posedge clk);
  endtask

  // Idle first so that no refill is still outstanding
  task automatic flush_all();
    wait_cycles(16);
    flush <= 1'b1;
    @(posedge clk);
    flush <= 1'b0;
    @(posedge clk);
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  task automatic random_fetches();
    enable_prefetch <= 1'b1;
    for (int i = 0; i < 300 && !timed_out; i++) begin
      fetch_word(rand_addr());
    end
    u_checker.finish_test("random data");
  endtask

  task automatic refetch_filled_lines();
    addr_t a;
    addr_t b;
    enable_prefetch <= 1'b0;
    flush_all();
    for (int i = 0; i < 8 && !timed_out; i++) begin
      a = rand_addr();
      b = rand_addr();
      fetch_word(a);
      fetch_word({a[31:4], b[3:0]});
      u_checker.check_first_cycle(1'b1, 1'b1, 1'b0);
    end
    u_checker.finish_test("hit after fill");
  endtask

  task automatic probe_prefetch(input logic enable, input string name);
    addr_t a;
    enable_prefetch <= enable;
    for (int i = 0; i < 8 && !timed_out; i++) begin
      flush_all();
      u_checker.mark_prefetch();
      a = rand_addr();
      fetch_word(a);
      wait_cycles(16);
      // The hit cycle that ends the first fetch latches exactly one prefetch
      if (enable) begin
        u_checker.compare_prefetch_count(1);
      end
      fetch_word(u_checker.predicted_line(a));
      if (enable) begin
        u_checker.check_first_cycle(1'b1, 1'b1, 1'b0);
      end else begin
        u_checker.check_first_cycle(1'b0, 1'b0, 1'b1);
        u_checker.compare_prefetch_count(0);
      end
    end
    u_checker.finish_test(name);
  endtask

  task automatic refetch_after_flush();
    addr_t a;
    enable_prefetch <= 1'b0;
    for (int i = 0; i < 8 && !timed_out; i++) begin
      a = rand_addr();
      fetch_word(a);
      flush_all();
      fetch_word(a);
      u_checker.check_first_cycle(1'b0, 1'b0, 1'b1);
    end
    u_checker.finish_test("flush");
  endtask

  // Five distinct lines through four ways evict the first one
  task automatic evict_round_robin();
    addr_t base;
    addr_t first;
    enable_prefetch <= 1'b0;
    for (int i = 0; i < 4 && !timed_out; i++) begin
      flush_all();
      base  = rand_addr();
      first = base;
      for (int k = 0; k < 5; k++) begin
        fetch_word(32'h0000_2000 | ((base + addr_t'(k * 16)) & 32'h0000_03fc));
      end
      fetch_word(first);
      u_checker.check_first_cycle(1'b0, 1'b0, 1'b1);
    end
    u_checker.finish_test("eviction");
  endtask

  initial begin
    seed            = 32'h7306_9d45;
    rst_n           = 1'b0;
    fetch_addr      = '0;
    fetch_valid     = 1'b0;
    flush           = 1'b0;
    enable_prefetch = 1'b0;
    timed_out       = 1'b0;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    random_fetches();
    if (!timed_out) refetch_filled_lines();
    if (!timed_out) probe_prefetch(1'b1, "prefetch target");
    if (!timed_out) probe_prefetch(1'b0, "prefetch off");
    if (!timed_out) refetch_after_flush();
    if (!timed_out) evict_round_robin();
    u_checker.report();
    if (timed_out || u_checker.error_count != 0 ||
        uut.i_l0_icache.u_assertions.fail_count != 0) begin
      $display("Test failed");
    end else begin
      $display("Test passed");
    end
    $finish;
  end

endmodule

// File: filelist.f
icache_pkg.sv
line_memory.sv
branch_prefetch_predictor.sv
l0_icache.sv
icache_subsys_top.sv
icache_subsys_assertions.sv
icache_subsys_checker.sv
tb_icache_subsys.sv
